//--- logic/lsu_pkg.sv
// load/store unit shared types: bus widths, access type and request/response structs

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////////////////////

  // byte address as computed by the execute stage
  typedef logic [31:0] addr_t;
  // one 64-bit bus beat, also used for the extended load result
  typedef logic [63:0] bus_data_t;
  // one enable per byte lane
  typedef logic [7:0]  be_t;
  // byte position inside a beat
  typedef logic [2:0]  lane_off_t;
  // byte offset of store data inside the source register
  typedef logic [1:0]  reg_off_t;

  // access size, encoding 2'b11 is illegal
  typedef enum logic [1:0] {
    dt_word = 2'b00,
    dt_half = 2'b01,
    dt_byte = 2'b10
  } data_type_e;

  ////////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////////

  // access from the execute stage, held stable until data_valid_o
  typedef struct packed {
    logic       we;
    data_type_e data_type;
    logic       sign_ext;
    reg_off_t   reg_offset;
    bus_data_t  wdata;
    addr_t      addr;
  } lsu_req_t;

  // bus request, only meaningful in the cycle of request and grant
  typedef struct packed {
    addr_t     addr;
    logic      we;
    be_t       be;
    bus_data_t wdata;
  } mem_req_t;

  // bus response, err only counts together with rvalid
  typedef struct packed {
    logic      rvalid;
    logic      err;
    bus_data_t rdata;
  } mem_rsp_t;

endpackage

//--- logic/lsu_ctrl_fsm.sv
// transaction FSM of the load/store unit with misaligned split and error reporting
`timescale 1ns/1ns

module lsu_ctrl_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_ex_i,
  input  lsu_pkg::data_type_e data_type_i,
  input  lsu_pkg::lane_off_t  lane_off_i,
  input  lsu_pkg::addr_t      addr_i,
  input  logic               data_gnt_i,
  input  logic               rvalid_i,
  input  logic               err_i,
  input  logic               we_q_i,
  output logic               data_req_o,
  output logic               data_valid_o,
  output logic               addr_incr_req_o,
  output logic               second_part_o,
  output logic               accept_o,
  output logic               first_beat_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               busy_o,
  output lsu_pkg::addr_t      addr_last_o
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_wait_gnt_mis,
    st_wait_rvalid_mis,
    st_wait_gnt,
    st_wait_rvalid
  } lsu_state_e;

  lsu_state_e state_q, state_d;
  // set once the first half of a split access has been granted
  logic       second_part_q, second_part_d;
  logic       split;
  addr_t      addr_last_q;

  // word crossing lane 7 or half word starting in lane 7
  assign split = ((data_type_i == dt_word) && (lane_off_i > 3'd4)) ||
                 ((data_type_i == dt_half) && (lane_off_i == 3'd7));

  ////////////////////////////////////////////////////////////////////////////
  // next state and strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_part_d   = second_part_q;
    data_req_o      = 1'b0;
    data_valid_o    = 1'b0;
    addr_incr_req_o = 1'b0;
    first_beat_o    = 1'b0;
    unique case (state_q)
      st_idle: begin
        if (req_ex_i) begin
          data_req_o = 1'b1;
          if (data_gnt_i) begin
            second_part_d = split;
            state_d       = split ? st_wait_rvalid_mis : st_wait_rvalid;
          end else begin
            state_d = split ? st_wait_gnt_mis : st_wait_gnt;
          end
        end
      end
      st_wait_gnt_mis: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          second_part_d = 1'b1;
          state_d       = st_wait_rvalid_mis;
        end
      end
      st_wait_rvalid_mis: begin
        // core switches to addr_last_o + 8 while this is high
        addr_incr_req_o = 1'b1;
        if (rvalid_i) begin
          if (err_i) begin
            // a failed first half drops the second half
            data_valid_o  = 1'b1;
            second_part_d = 1'b0;
            state_d       = st_idle;
          end else begin
            first_beat_o = ~we_q_i;
            data_req_o   = 1'b1;
            state_d      = data_gnt_i ? st_wait_rvalid : st_wait_gnt;
          end
        end
      end
      st_wait_gnt: begin
        addr_incr_req_o = second_part_q;
        data_req_o      = 1'b1;
        if (data_gnt_i) begin
          state_d = st_wait_rvalid;
        end
      end
      st_wait_rvalid: begin
        if (rvalid_i) begin
          data_valid_o  = 1'b1;
          second_part_d = 1'b0;
          state_d       = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  assign accept_o      = data_req_o & data_gnt_i;
  assign second_part_o = second_part_q;

  // error type comes from the store flag captured at accept
  assign load_err_o  = rvalid_i & err_i & ~we_q_i;
  assign store_err_o = rvalid_i & err_i & we_q_i;

  // busy from the first request until the final response
  assign busy_o      = (state_q == st_wait_rvalid) | (state_q == st_wait_rvalid_mis) |
                       data_req_o;
  assign addr_last_o = addr_last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= st_idle;
      second_part_q <= 1'b0;
      addr_last_q   <= '0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      // keep the failing address for the trap value
      if (accept_o && !(load_err_o || store_err_o)) begin
        addr_last_q <= addr_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // a response with nothing outstanding
  a_no_rvalid_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == st_idle) |-> !rvalid_i);

  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_i |-> rvalid_i);

  // bus must not grant a new beat before the pending one returns
  a_no_gnt_waiting: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((state_q == st_wait_rvalid) && data_gnt_i) |-> rvalid_i);

endmodule

//--- logic/lsu_wdata_align.sv
// store side of the load/store unit: byte enables, lane rotation and aligned address
`timescale 1ns/1ns

module lsu_wdata_align (
  input  lsu_pkg::lsu_req_t req_i,
  input  logic             second_part_i,
  output lsu_pkg::mem_req_t mem_req_o
);

  import lsu_pkg::*;

  lane_off_t    lane_off;
  // byte distance between register position and lane position
  lane_off_t    rot;
  be_t          size_mask;
  logic [15:0]  be_wide;
  logic [127:0] wdata_dup;

  assign lane_off = req_i.addr[2:0];

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (req_i.data_type)
      dt_word: size_mask = 8'b0000_1111;
      dt_half: size_mask = 8'b0000_0011;
      dt_byte: size_mask = 8'b0000_0001;
      default: size_mask = 8'b0000_0000;
    endcase
  end

  // upper byte holds the lanes that spill past lane 7
  assign be_wide = {8'h00, size_mask} << lane_off;

  ////////////////////////////////////////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////////////////////////////////////////

  // modulo 8 falls out of the 3 bit subtraction
  assign rot = lane_off - {1'b0, req_i.reg_offset};

  // rotate left by rot bytes via a doubled copy
  assign wdata_dup = {req_i.wdata, req_i.wdata} << {rot, 3'b000};

  assign mem_req_o.addr  = {req_i.addr[31:3], 3'b000};
  assign mem_req_o.we    = req_i.we;
  assign mem_req_o.be    = second_part_i ? be_wide[15:8] : be_wide[7:0];
  assign mem_req_o.wdata = wdata_dup[127:64];

  // encoding 2'b11 has no byte enable pattern
  always_comb begin
    assert (req_i.data_type inside {dt_word, dt_half, dt_byte})
      else $error("illegal access type on store path");
  end

endmodule

//--- logic/lsu_rdata_align.sv
// load side of the load/store unit: attribute capture, beat merge and extension
`timescale 1ns/1ns

module lsu_rdata_align (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               accept_i,
  input  logic               first_beat_i,
  input  lsu_pkg::data_type_e data_type_i,
  input  logic               sign_ext_i,
  input  logic               we_i,
  input  lsu_pkg::lane_off_t  lane_off_i,
  input  lsu_pkg::bus_data_t  rdata_i,
  output logic               we_q_o,
  output lsu_pkg::bus_data_t  rdata_o
);

  import lsu_pkg::*;

  lane_off_t    off_q;
  data_type_e   type_q;
  logic         sign_ext_q;
  logic         we_q;
  // low beat of a split load
  bus_data_t    first_q;
  logic         split_q;
  bus_data_t    lo_beat;
  logic [127:0] seq;
  logic [127:0] shifted;
  logic [31:0]  raw;

  ////////////////////////////////////////////////////////////////////////////
  // capture at accept
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      off_q      <= '0;
      type_q     <= dt_word;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (accept_i) begin
      off_q      <= lane_off_i;
      type_q     <= data_type_i;
      sign_ext_q <= sign_ext_i;
      we_q       <= we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (first_beat_i) begin
      first_q <= rdata_i;
    end
  end

  assign we_q_o = we_q;

  ////////////////////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////////////////////

  // same split rule as the FSM, from the captured attributes
  assign split_q = ((type_q == dt_word) && (off_q > 3'd4)) ||
                   ((type_q == dt_half) && (off_q == 3'd7));

  // an unsplit access lies fully inside the current beat
  assign lo_beat = split_q ? first_q : rdata_i;
  assign seq     = {rdata_i, lo_beat};
  assign shifted = seq >> {off_q, 3'b000};
  assign raw     = shifted[31:0];

  // zero or sign extension to 64 bits
  always_comb begin
    unique case (type_q)
      dt_word: rdata_o = {{32{sign_ext_q & raw[31]}}, raw};
      dt_half: rdata_o = {{48{sign_ext_q & raw[15]}}, raw[15:0]};
      dt_byte: rdata_o = {{56{sign_ext_q & raw[7]}}, raw[7:0]};
      default: rdata_o = '0;
    endcase
  end

endmodule

//--- logic/lsu_top.sv
// load/store unit top level between the execute stage and the 64-bit data bus
`timescale 1ns/1ns

module lsu_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_ex_i,
  input  lsu_pkg::lsu_req_t  lsu_req_i,
  output logic              data_req_o,
  input  logic              data_gnt_i,
  output lsu_pkg::mem_req_t  mem_req_o,
  input  lsu_pkg::mem_rsp_t  mem_rsp_i,
  output lsu_pkg::bus_data_t rdata_ex_o,
  output logic              data_valid_o,
  output logic              addr_incr_req_o,
  output logic              load_err_o,
  output logic              store_err_o,
  output logic              busy_o,
  output lsu_pkg::addr_t     addr_last_o
);

  import lsu_pkg::*;

  lane_off_t lane_off;
  logic      second_part;
  logic      accept;
  logic      first_beat;
  // store flag of the access that owns the pending response
  logic      we_q;

  assign lane_off = lsu_req_i.addr[2:0];

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_ex_i        (req_ex_i),
    .data_type_i     (lsu_req_i.data_type),
    .lane_off_i      (lane_off),
    .addr_i          (lsu_req_i.addr),
    .data_gnt_i      (data_gnt_i),
    .rvalid_i        (mem_rsp_i.rvalid),
    .err_i           (mem_rsp_i.err),
    .we_q_i          (we_q),
    .data_req_o      (data_req_o),
    .data_valid_o    (data_valid_o),
    .addr_incr_req_o (addr_incr_req_o),
    .second_part_o   (second_part),
    .accept_o        (accept),
    .first_beat_o    (first_beat),
    .load_err_o      (load_err_o),
    .store_err_o     (store_err_o),
    .busy_o          (busy_o),
    .addr_last_o     (addr_last_o)
  );

  lsu_wdata_align u_wdata_align (
    .req_i         (lsu_req_i),
    .second_part_i (second_part),
    .mem_req_o     (mem_req_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .first_beat_i (first_beat),
    .data_type_i  (lsu_req_i.data_type),
    .sign_ext_i   (lsu_req_i.sign_ext),
    .we_i         (lsu_req_i.we),
    .lane_off_i   (lane_off),
    .rdata_i      (mem_rsp_i.rdata),
    .we_q_o       (we_q),
    .rdata_o      (rdata_ex_o)
  );

endmodule

//--- tb/lsu_checker.sv
// load/store unit checker that compares the DUT ports with the golden expectations
`timescale 1ns/1ns

module lsu_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               data_req_i,
  input  logic               data_gnt_i,
  input  lsu_pkg::mem_req_t  mem_req_i,
  input  lsu_pkg::bus_data_t rdata_ex_i,
  input  logic               data_valid_i,
  input  logic               addr_incr_req_i,
  input  logic               load_err_i,
  input  logic               store_err_i,
  input  logic               busy_i,
  input  lsu_pkg::addr_t     addr_last_i,
  input  logic               exp_we_i,
  input  lsu_pkg::addr_t     exp_addr_i,
  input  lsu_pkg::be_t       exp_be1_i,
  input  lsu_pkg::bus_data_t exp_wd1_i,
  input  lsu_pkg::be_t       exp_be2_i,
  input  lsu_pkg::bus_data_t exp_wd2_i,
  input  lsu_pkg::bus_data_t exp_result_i,
  input  logic               exp_err_i,
  output int unsigned        error_count_o,
  output int unsigned        done_count_o
);

  import lsu_pkg::*;

  int unsigned error_count = 0;
  int unsigned done_count  = 0;
  // accepted requests of the access in flight
  int unsigned accepts     = 0;
  int unsigned full_parts;
  int unsigned bus_parts;
  logic        incr_seen   = 1'b0;
  // high from the first request of an access until its data_valid_o
  logic        in_flight   = 1'b0;
  addr_t       beat_addr;

  assign error_count_o = error_count;
  assign done_count_o  = done_count;

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("error %s expected %h actual %h", name, exp_val, act_val);
      error_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t ns: %s", $time, what);
    error_count++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sample on the falling edge between drive and capture
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      full_parts = (exp_be2_i != 8'h00) ? 2 : 1;
      // an error on the first part cancels the second
      bus_parts  = exp_err_i ? 1 : full_parts;
      beat_addr  = {exp_addr_i[31:3], 3'b000};
      if (addr_incr_req_i) begin
        incr_seen = 1'b1;
      end
      if (data_req_i) begin
        in_flight = 1'b1;
      end
      if (in_flight && !busy_i) begin
        report_failure("busy_o low while an access is in flight");
      end
      if (data_req_i && data_gnt_i) begin
        if (accepts == 0) begin
          check_value("mem_req_o.be", {56'h0, exp_be1_i}, {56'h0, mem_req_i.be});
          check_value("mem_req_o.addr", {32'h0, beat_addr}, {32'h0, mem_req_i.addr});
          if (exp_we_i) begin
            check_value("mem_req_o.wdata", exp_wd1_i, mem_req_i.wdata);
          end
        end else if (accepts == 1) begin
          if (!incr_seen) begin
            report_failure("second request without addr_incr_req_o before it");
          end
          check_value("mem_req_o.be", {56'h0, exp_be2_i}, {56'h0, mem_req_i.be});
          check_value("mem_req_o.addr", {32'h0, beat_addr + 32'd8},
                      {32'h0, mem_req_i.addr});
          if (exp_we_i) begin
            check_value("mem_req_o.wdata", exp_wd2_i, mem_req_i.wdata);
          end
        end else begin
          report_failure("more than two bus requests for one access");
        end
        check_value("mem_req_o.we", {63'h0, exp_we_i}, {63'h0, mem_req_i.we});
        accepts++;
      end
      if (data_valid_i) begin
        if (accepts != bus_parts) begin
          report_failure("wrong number of bus requests for the access");
        end
        check_value("load_err_o", {63'h0, exp_err_i & ~exp_we_i}, {63'h0, load_err_i});
        check_value("store_err_o", {63'h0, exp_err_i & exp_we_i}, {63'h0, store_err_i});
        if (!exp_we_i && !exp_err_i) begin
          check_value("rdata_ex_o", exp_result_i, rdata_ex_i);
        end
        if (exp_err_i) begin
          check_value("addr_last_o", {32'h0, exp_addr_i}, {32'h0, addr_last_i});
        end
        accepts   = 0;
        incr_seen = 1'b0;
        in_flight = 1'b0;
        done_count++;
      end
    end
  end

endmodule

//--- tb/tb_lsu.sv
// load/store unit testbench with clock, reset, golden stimulus, core driver and bus model
`timescale 1ns/1ns

module tb_lsu;

  import lsu_pkg::*;

  localparam int unsigned NUM_ACC = 21;
  // columns per golden line
  localparam int unsigned NUM_COL = 16;
  localparam int unsigned TIMEOUT = 50;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       req_ex;
  lsu_req_t   lsu_req;
  logic       data_req;
  logic       data_gnt;
  mem_req_t   mem_req;
  mem_rsp_t   mem_rsp;
  bus_data_t  rdata_ex;
  logic       data_valid;
  logic       addr_incr_req;
  logic       load_err;
  logic       store_err;
  logic       busy;
  addr_t      addr_last;

  // expectations of the access in flight
  logic       exp_we;
  addr_t      exp_addr;
  be_t        exp_be1;
  bus_data_t  exp_wd1;
  be_t        exp_be2;
  bus_data_t  exp_wd2;
  bus_data_t  exp_result;
  logic       exp_err;

  logic [63:0] golden [0:NUM_ACC*NUM_COL-1];
  integer      seed = 32'hdd21;
  logic        timed_out = 1'b0;
  int unsigned error_count;
  int unsigned done_count;

  always #2 clk_i = ~clk_i;

  lsu_top UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_ex_i        (req_ex),
    .lsu_req_i       (lsu_req),
    .data_req_o      (data_req),
    .data_gnt_i      (data_gnt),
    .mem_req_o       (mem_req),
    .mem_rsp_i       (mem_rsp),
    .rdata_ex_o      (rdata_ex),
    .data_valid_o    (data_valid),
    .addr_incr_req_o (addr_incr_req),
    .load_err_o      (load_err),
    .store_err_o     (store_err),
    .busy_o          (busy),
    .addr_last_o     (addr_last)
  );

  lsu_checker u_checker (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .data_req_i (data_req), .data_gnt_i (data_gnt), .mem_req_i (mem_req),
    .rdata_ex_i (rdata_ex), .data_valid_i (data_valid), .addr_incr_req_i (addr_incr_req),
    .load_err_i (load_err), .store_err_i (store_err), .busy_i (busy),
    .addr_last_i (addr_last), .exp_we_i (exp_we), .exp_addr_i (exp_addr),
    .exp_be1_i (exp_be1), .exp_wd1_i (exp_wd1), .exp_be2_i (exp_be2),
    .exp_wd2_i (exp_wd2), .exp_result_i (exp_result), .exp_err_i (exp_err),
    .error_count_o (error_count), .done_count_o (done_count)
  );

  ////////////////////////////////////////////////////////////////////////////
  // execute-stage driver and bus model
  ////////////////////////////////////////////////////////////////////////////

  // advance one cycle and change inputs 1 ns after the edge
  task automatic step();
    @(posedge clk_i);
    #1;
    mem_rsp = '0;
    // core follows the split with the next beat address
    if (addr_incr_req) begin
      lsu_req.addr = addr_last + 32'd8;
    end
  endtask

  task automatic grant_request(input int unsigned delay);
    int unsigned n;
    n = 0;
    repeat (delay) begin
      data_gnt = 1'b0;
      step();
    end
    data_gnt = 1'b1;
    @(negedge clk_i);
    while (!data_req) begin
      n++;
      if (n >= TIMEOUT) begin
        $display("timeout: no bus request while grant was offered");
        timed_out = 1'b1;
        return;
      end
      step();
      @(negedge clk_i);
    end
    step();
    data_gnt = 1'b0;
  endtask

  // rvalid 1 to 3 cycles after the accepting edge
  task automatic return_response(input int unsigned delay, input bus_data_t beat,
                                 input logic err);
    repeat (delay - 1) step();
    mem_rsp.rvalid = 1'b1;
    mem_rsp.err    = err;
    mem_rsp.rdata  = beat;
  endtask

  task automatic wait_data_valid();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!data_valid) begin
      n++;
      if (n >= TIMEOUT) begin
        $display("timeout: data_valid_o never pulsed after the last response");
        timed_out = 1'b1;
        return;
      end
      step();
      @(negedge clk_i);
    end
  endtask

  task automatic run_access(input int unsigned idx);
    int unsigned b;
    logic        err1;
    b    = idx * NUM_COL;
    err1 = golden[b+8][0];
    lsu_req.we         = golden[b][0];
    lsu_req.data_type  = data_type_e'(golden[b+1][1:0]);
    lsu_req.sign_ext   = golden[b+2][0];
    lsu_req.reg_offset = golden[b+3][1:0];
    lsu_req.addr       = golden[b+4][31:0];
    lsu_req.wdata      = golden[b+5];
    exp_we     = golden[b][0];
    exp_addr   = golden[b+4][31:0];
    exp_be1    = golden[b+10][7:0];
    exp_wd1    = golden[b+11];
    exp_be2    = golden[b+12][7:0];
    exp_wd2    = golden[b+13];
    exp_result = golden[b+14];
    exp_err    = golden[b+15][0];
    req_ex     = 1'b1;
    grant_request($unsigned($random(seed)) % 4);
    if (timed_out) return;
    return_response(1 + $unsigned($random(seed)) % 3, golden[b+6], err1);
    // second part of a split may be granted in the rvalid cycle
    if ((golden[b+12][7:0] != 8'h00) && !err1) begin
      grant_request($unsigned($random(seed)) % 4);
      if (timed_out) return;
      return_response(1 + $unsigned($random(seed)) % 3, golden[b+7], golden[b+9][0]);
    end
    wait_data_valid();
    if (timed_out) return;
    step();
    req_ex  = 1'b0;
    lsu_req = '0;
    step();
  endtask

  initial begin
    rst_ni     = 1'b0;
    req_ex     = 1'b0;
    lsu_req    = '0;
    data_gnt   = 1'b0;
    mem_rsp    = '0;
    exp_we     = 1'b0;
    exp_addr   = '0;
    exp_be1    = '0;
    exp_wd1    = '0;
    exp_be2    = '0;
    exp_wd2    = '0;
    exp_result = '0;
    exp_err    = 1'b0;
    $readmemh("tb/lsu_golden.txt", golden);
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int unsigned i = 0; i < NUM_ACC; i++) begin
      if (!timed_out) begin
        run_access(i);
      end
    end
    step();
    if (!timed_out && done_count != NUM_ACC) begin
      $display("failure: only %0d of %0d accesses completed", done_count, NUM_ACC);
    end
    $display("accesses done %0d of %0d, errors %0d", done_count, NUM_ACC, error_count);
    if (timed_out || error_count != 0 || done_count != NUM_ACC) begin
      $display("Verification failed");
    end else begin
      $display("Verification passed");
    end
    $finish;
  end

endmodule

//--- tb/lsu_golden.txt
// we type sext roff addr wdata beat1 beat2 err1 err2 be1 wd1 be2 wd2 result err
// type 0 word, 1 half, 2 byte; all values in hex
0 0 0 0 00001000 0 f7e6d5c4b3a29180 0 0 0 0f 0 00 0 00000000b3a29180 0
0 0 1 0 00001004 0 f7e6d5c4b3a29180 0 0 0 f0 0 00 0 fffffffff7e6d5c4 0
0 1 1 0 00001002 0 f7e6d5c4b3a29180 0 0 0 0c 0 00 0 ffffffffffffb3a2 0
0 1 0 0 00001006 0 f7e6d5c4b3a29180 0 0 0 c0 0 00 0 000000000000f7e6 0
0 2 1 0 00001001 0 f7e6d5c4b3a29180 0 0 0 02 0 00 0 ffffffffffffff91 0
0 2 0 0 00001005 0 f7e6d5c4b3a29180 0 0 0 20 0 00 0 00000000000000d5 0
0 2 1 0 00002003 0 0f1e2d3c4b5a6978 0 0 0 08 0 00 0 000000000000004b 0
1 0 0 0 00003000 1122334455667788 0 0 0 0 0f 1122334455667788 00 0 0 0
1 1 0 0 00003002 1122334455667788 0 0 0 0 0c 3344556677881122 00 0 0 0
1 2 0 1 00003005 1122334455667788 0 0 0 0 20 5566778811223344 00 0 0 0
1 0 0 2 00003004 1122334455667788 0 0 0 0 f0 3344556677881122 00 0 0 0
1 1 0 3 00003001 1122334455667788 0 0 0 0 06 7788112233445566 00 0 0 0
0 0 0 0 00004005 0 f7e6d5c4b3a29180 0f1e2d3c4b5a6978 0 0 e0 0 01 0 0000000078f7e6d5 0
0 0 1 0 00004006 0 f7e6d5c4b3a29180 0f1e2d3c4b5a6978 0 0 c0 0 03 0 000000006978f7e6 0
0 0 1 0 00004007 0 0f1e2d3c4b5a6978 f7e6d5c4b3a29180 0 0 80 0 07 0 ffffffffa291800f 0
0 1 1 0 00004ff7 0 0f1e2d3c4b5a6978 f7e6d5c4b3a29180 0 0 80 0 01 0 ffffffffffff800f 0
1 0 0 0 00005006 1122334455667788 0 0 0 0 c0 7788112233445566 03 7788112233445566 0 0
1 1 0 2 00005007 1122334455667788 0 0 0 0 80 6677881122334455 01 6677881122334455 0 0
0 0 0 0 00006005 0 f7e6d5c4b3a29180 0f1e2d3c4b5a6978 1 0 e0 0 01 0 0 1
1 2 0 0 00006103 1122334455667788 0 0 1 0 08 4455667788112233 00 0 0 1
1 1 0 0 00006207 1122334455667788 0 0 1 0 80 8811223344556677 01 8811223344556677 0 1

//--- src.f
logic/lsu_pkg.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_wdata_align.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
tb/lsu_checker.sv
tb/tb_lsu.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_lsu -f src.f -o sim_lsu \
  > build.log 2>&1 || { cat build.log; echo "Verification failed" > sim.log; }
[ -f sim.log ] || ./obj_dir/sim_lsu > sim.log 2>&1 || echo "Verification failed" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
